/* hdl/pio_pkg.sv */
// PIO state machine package
// Opcodes, field encodings, instruction views and shared structs
package pio_pkg;

  localparam int DATA_W     = 32;   // Data and pin width
  localparam int PC_W       = 5;
  localparam int PROG_DEPTH = 32;
  localparam int INSTR_W    = 16;

  // Major opcodes, instr[15:13]
  localparam logic [2:0] OP_JMP      = 3'd0;
  localparam logic [2:0] OP_WAIT     = 3'd1;
  localparam logic [2:0] OP_IN       = 3'd2;
  localparam logic [2:0] OP_OUT      = 3'd3;
  localparam logic [2:0] OP_PUSHPULL = 3'd4;
  localparam logic [2:0] OP_MOV      = 3'd5;
  localparam logic [2:0] OP_SET      = 3'd7;

  // Source / destination codes, shared by IN, OUT, MOV and SET
  localparam logic [2:0] SRC_PINS    = 3'd0;
  localparam logic [2:0] SRC_X       = 3'd1;
  localparam logic [2:0] SRC_Y       = 3'd2;
  localparam logic [2:0] SRC_NULL    = 3'd3;
  localparam logic [2:0] DST_PINDIRS = 3'd4;
  localparam logic [2:0] SRC_ISR     = 3'd6;
  localparam logic [2:0] SRC_OSR     = 3'd7;

  // JMP conditions
  localparam logic [2:0] COND_ALWAYS = 3'd0;
  localparam logic [2:0] COND_XZ     = 3'd1;
  localparam logic [2:0] COND_XDEC   = 3'd2;
  localparam logic [2:0] COND_YZ     = 3'd3;
  localparam logic [2:0] COND_YDEC   = 3'd4;
  localparam logic [2:0] COND_XNEY   = 3'd5;
  localparam logic [2:0] COND_PIN    = 3'd6;

  // MOV bit operations
  localparam logic [1:0] MOVOP_NONE = 2'd0;
  localparam logic [1:0] MOVOP_INV  = 2'd1;
  localparam logic [1:0] MOVOP_REV  = 2'd2;

  typedef struct packed {
    logic [2:0] op;
    logic [4:0] rsvd;   // Delay/side-set field, not implemented
    logic [2:0] arg1;
    logic [4:0] arg2;
  } instr_gen_t;

  typedef struct packed {
    logic [2:0] op;
    logic [4:0] rsvd;
    logic [2:0] dest;
    logic [1:0] mov_op;
    logic [2:0] mov_src;
  } instr_mov_t;

  typedef union packed {
    instr_gen_t gen;
    instr_mov_t mov;
  } instr_u;

  typedef struct packed {
    logic [PC_W-1:0] wrap_target;
    logic [PC_W-1:0] wrap_top;
    logic [4:0]      out_base;
    logic [5:0]      out_count;
    logic [4:0]      set_base;
    logic [2:0]      set_count;
    logic [4:0]      in_base;
    logic [4:0]      jmp_pin;
    logic            in_shift_right;
    logic            out_shift_right;
  } sm_cfg_t;

  typedef struct packed {
    logic               we;
    logic [PC_W-1:0]    addr;
    logic [INSTR_W-1:0] instr;
  } prog_wr_t;

  typedef struct packed {
    logic              req;
    logic [DATA_W-1:0] data;
  } link_t;

endpackage

/* hdl/tx_receiver.sv */
// TX link receiver
// Four-phase req/ack slave feeding a one-word holding slot
`timescale 1ns/10ps
module tx_receiver import pio_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  link_t             tx_link,
  output logic              tx_ack,
  input  logic              pull_take,
  output logic [DATA_W-1:0] tx_word,
  output logic              tx_valid
);

  logic accept;   // Latch a new word this edge

  assign accept = tx_link.req && !tx_ack && !tx_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      tx_ack   <= 1'b0;
      tx_valid <= 1'b0;
    end else begin
      if (accept) begin
        tx_ack   <= 1'b1;
        tx_valid <= 1'b1;
      end else if (tx_ack && !tx_link.req) begin
        tx_ack <= 1'b0;   // Phase 4
      end
      if (pull_take) tx_valid <= 1'b0;   // Slot drained by PULL
    end
  end

  always_ff @(posedge clk) begin
    if (accept) tx_word <= tx_link.data;
  end

  a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(tx_ack) |-> $past(tx_link.req));

  a_take_needs_word: assert property (@(posedge clk) disable iff (reset)
    pull_take |-> tx_valid);

endmodule

/* hdl/sequencer.sv */
// Instruction sequencer
// Program memory, program counter with wrap and the run gate
`timescale 1ns/10ps
module sequencer import pio_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            en,
  input  sm_cfg_t         cfg,
  input  prog_wr_t        prog_wr,
  input  logic            stall,
  input  logic            jump,
  input  logic [PC_W-1:0] jump_addr,
  output instr_u          instr,
  output logic            step,
  output logic [PC_W-1:0] pc
);

  instr_u          prog_mem [PROG_DEPTH];
  logic [PC_W-1:0] pc_next;

  // Host load port, only legal while stopped
  always_ff @(posedge clk) begin
    if (prog_wr.we) prog_mem[prog_wr.addr] <= prog_wr.instr;
  end

  assign instr = prog_mem[pc];   // Asynchronous read
  assign step  = en;

  always_comb begin
    if (jump) begin
      pc_next = jump_addr;
    end else if (pc == cfg.wrap_top) begin
      pc_next = cfg.wrap_target;
    end else begin
      pc_next = pc + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (step && !stall) begin
      pc <= pc_next;
    end
  end

  a_no_load_while_running: assert property (@(posedge clk) disable iff (reset)
    prog_wr.we |-> !en);

endmodule

/* hdl/exec_unit.sv */
// Execution unit
// Decodes the current instruction and updates X, Y, ISR, OSR and the pin registers
`timescale 1ns/10ps
module exec_unit import pio_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  sm_cfg_t           cfg,
  input  instr_u            instr,
  input  logic              step,
  input  logic [DATA_W-1:0] gpio_in,
  input  logic [DATA_W-1:0] tx_word,
  input  logic              tx_valid,
  input  logic              rx_busy,
  output logic              pull_take,
  output logic              push_put,
  output logic [DATA_W-1:0] push_word,
  output logic              stall,
  output logic              jump,
  output logic [PC_W-1:0]   jump_addr,
  output logic [DATA_W-1:0] gpio_out,
  output logic [DATA_W-1:0] gpio_dir
);

  logic [DATA_W-1:0]   x, y, isr, osr;
  logic [5:0]          isr_count, osr_count;
  logic [2:0]          op, arg1;
  logic [4:0]          arg2;
  logic [5:0]          shift_n, shift_inv;
  logic [2*DATA_W-1:0] in_pins2;
  logic [DATA_W-1:0]   in_pins;
  logic [2:0]          src_code;
  logic [DATA_W-1:0]   src_val, mov_val, set_data;
  logic [DATA_W-1:0]   isr_shifted, osr_shifted, out_data;
  logic                cond_ok, wait_pin, fire;

  // Writes count pins from base upwards, wrapping past pin 31
  function automatic logic [DATA_W-1:0] pin_write(input logic [DATA_W-1:0] old_val,
                                                  input logic [DATA_W-1:0] val,
                                                  input logic [4:0] base,
                                                  input logic [5:0] count);
    logic [DATA_W-1:0]   low_mask;
    logic [2*DATA_W-1:0] rot_val, rot_mask;
    low_mask = (count >= 6'd32) ? '1 : ((DATA_W'(1) << count) - 1'b1);
    rot_val  = {val, val} << base;
    rot_mask = {low_mask, low_mask} << base;
    return (old_val & ~rot_mask[2*DATA_W-1:DATA_W]) |
           (rot_val[2*DATA_W-1:DATA_W] & rot_mask[2*DATA_W-1:DATA_W]);
  endfunction

  function automatic logic [5:0] sat_add(input logic [5:0] count, input logic [5:0] n);
    logic [6:0] sum;
    sum = count + n;
    return (sum > 7'd32) ? 6'd32 : sum[5:0];
  endfunction

  assign op        = instr.gen.op;
  assign arg1      = instr.gen.arg1;
  assign arg2      = instr.gen.arg2;
  assign shift_n   = (arg2 == '0) ? 6'd32 : {1'b0, arg2};   // 0 encodes 32
  assign shift_inv = 6'd32 - shift_n;
  assign in_pins2  = {gpio_in, gpio_in} >> cfg.in_base;
  assign in_pins   = in_pins2[DATA_W-1:0];
  assign set_data  = {{(DATA_W-5){1'b0}}, arg2};
  assign src_code  = (op == OP_MOV) ? instr.mov.mov_src : arg1;

  always_comb begin
    case (src_code)
      SRC_PINS: src_val = in_pins;
      SRC_X:    src_val = x;
      SRC_Y:    src_val = y;
      SRC_NULL: src_val = '0;
      SRC_ISR:  src_val = isr;
      SRC_OSR:  src_val = osr;
      default:  src_val = '0;
    endcase
    case (instr.mov.mov_op)
      MOVOP_NONE: mov_val = src_val;
      MOVOP_INV:  mov_val = ~src_val;
      MOVOP_REV:  mov_val = {<<{src_val}};
      default:    mov_val = src_val;   // Reserved op
    endcase
  end

  // Shifter paths for IN and OUT
  always_comb begin
    if (cfg.in_shift_right) begin
      isr_shifted = (isr >> shift_n) | (src_val << shift_inv);
    end else begin
      isr_shifted = (isr << shift_n) | ((src_val << shift_inv) >> shift_inv);
    end
    if (cfg.out_shift_right) begin
      out_data    = (osr << shift_inv) >> shift_inv;   // Low bits leave first
      osr_shifted = osr >> shift_n;
    end else begin
      out_data    = osr >> shift_inv;
      osr_shifted = osr << shift_n;
    end
  end

  always_comb begin
    case (arg1)
      COND_ALWAYS: cond_ok = 1'b1;
      COND_XZ:     cond_ok = (x == '0);
      COND_XDEC:   cond_ok = (x != '0);
      COND_YZ:     cond_ok = (y == '0);
      COND_YDEC:   cond_ok = (y != '0);
      COND_XNEY:   cond_ok = (x != y);
      COND_PIN:    cond_ok = gpio_in[cfg.jmp_pin];
      default:     cond_ok = 1'b0;
    endcase
    case (arg1[1:0])
      2'd0:    wait_pin = gpio_in[arg2];
      2'd1:    wait_pin = in_pins[arg2];
      default: wait_pin = arg1[2];   // IRQ wait not present
    endcase
    case (op)
      OP_WAIT:     stall = (wait_pin != arg1[2]);
      OP_PUSHPULL: stall = arg1[2] ? !tx_valid : rx_busy;
      default:     stall = 1'b0;
    endcase
  end

  assign fire      = step && !stall;
  assign jump      = (op == OP_JMP) && cond_ok;
  assign jump_addr = arg2;
  assign pull_take = fire && (op == OP_PUSHPULL) && arg1[2];
  assign push_put  = fire && (op == OP_PUSHPULL) && !arg1[2];
  assign push_word = isr;

  always_ff @(posedge clk) begin
    if (reset) begin
      x         <= '0;
      y         <= '0;
      isr       <= '0;
      osr       <= '0;
      isr_count <= '0;
      osr_count <= '0;
      gpio_out  <= '0;
      gpio_dir  <= '0;
    end else if (fire) begin
      case (op)
        OP_JMP: begin
          if (arg1 == COND_XDEC) x <= x - 1'b1;   // Post-decrement, always taken
          if (arg1 == COND_YDEC) y <= y - 1'b1;
        end
        OP_IN: begin
          isr       <= isr_shifted;
          isr_count <= sat_add(isr_count, shift_n);
        end
        OP_OUT: begin
          osr       <= osr_shifted;
          osr_count <= sat_add(osr_count, shift_n);
          case (arg1)
            SRC_PINS:    gpio_out <= pin_write(gpio_out, out_data, cfg.out_base, cfg.out_count);
            SRC_X:       x <= out_data;
            SRC_Y:       y <= out_data;
            DST_PINDIRS: gpio_dir <= pin_write(gpio_dir, out_data, cfg.out_base, cfg.out_count);
            default:     ;   // NULL discards
          endcase
        end
        OP_PUSHPULL: begin
          if (arg1[2]) begin
            osr       <= tx_word;
            osr_count <= '0;
          end else begin
            isr       <= '0;
            isr_count <= '0;
          end
        end
        OP_MOV: begin
          case (instr.mov.dest)
            SRC_PINS: gpio_out <= pin_write(gpio_out, mov_val, cfg.out_base, cfg.out_count);
            SRC_X:    x <= mov_val;
            SRC_Y:    y <= mov_val;
            SRC_ISR: begin
              isr       <= mov_val;
              isr_count <= '0;
            end
            SRC_OSR: begin
              osr       <= mov_val;
              osr_count <= '0;   // Treated as full
            end
            default: ;
          endcase
        end
        OP_SET: begin
          case (arg1)
            SRC_PINS:    gpio_out <= pin_write(gpio_out, set_data, cfg.set_base,
                                               {3'b0, cfg.set_count});
            SRC_X:       x <= set_data;
            SRC_Y:       y <= set_data;
            DST_PINDIRS: gpio_dir <= pin_write(gpio_dir, set_data, cfg.set_base,
                                               {3'b0, cfg.set_count});
            default:     ;
          endcase
        end
        default: ;
      endcase
    end
  end

  a_push_not_busy: assert property (@(posedge clk) disable iff (reset)
    push_put |-> !rx_busy);

endmodule

/* hdl/rx_sender.sv */
// RX link sender
// One-word output slot offered on a four-phase req/ack handshake
`timescale 1ns/10ps
module rx_sender import pio_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              push_put,
  input  logic [DATA_W-1:0] push_word,
  output logic              rx_busy,
  output link_t             rx_link,
  input  logic              rx_ack
);

  logic              req_q;
  logic [DATA_W-1:0] data_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      req_q   <= 1'b0;
      rx_busy <= 1'b0;
    end else if (push_put) begin
      req_q   <= 1'b1;
      rx_busy <= 1'b1;
    end else begin
      if (req_q && rx_ack) req_q <= 1'b0;   // Sink has the word
      if (rx_busy && !req_q && !rx_ack) rx_busy <= 1'b0;   // Ack released
    end
  end

  always_ff @(posedge clk) begin
    if (push_put) data_q <= push_word;
  end

  assign rx_link.req  = req_q;
  assign rx_link.data = data_q;

  a_data_stable: assert property (@(posedge clk) disable iff (reset)
    ($past(rx_link.req) && rx_link.req) |-> $stable(rx_link.data));

endmodule

/* hdl/pio_sm.sv */
// PIO state machine top
// TX receiver, sequencer, execution unit and RX sender
`timescale 1ns/10ps
module pio_sm import pio_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              en,
  input  sm_cfg_t           cfg,
  input  prog_wr_t          prog_wr,
  input  logic [DATA_W-1:0] gpio_in,
  input  link_t             tx_link,
  output logic              tx_ack,
  output link_t             rx_link,
  input  logic              rx_ack,
  output logic [DATA_W-1:0] gpio_out,
  output logic [DATA_W-1:0] gpio_dir,
  output logic [PC_W-1:0]   pc,
  output logic              stalled
);

  logic [DATA_W-1:0] tx_word, push_word;
  logic              tx_valid, pull_take, push_put, rx_busy;
  logic              step, stall, jump;
  logic [PC_W-1:0]   jump_addr;
  instr_u            instr;

  tx_receiver u_tx (.clk, .reset, .tx_link, .tx_ack, .pull_take, .tx_word, .tx_valid);

  sequencer u_seq (.clk, .reset, .en, .cfg, .prog_wr, .stall, .jump, .jump_addr,
                   .instr, .step, .pc);

  exec_unit u_exec (.clk, .reset, .cfg, .instr, .step, .gpio_in, .tx_word, .tx_valid,
                    .rx_busy, .pull_take, .push_put, .push_word, .stall, .jump,
                    .jump_addr, .gpio_out, .gpio_dir);

  rx_sender u_rx (.clk, .reset, .push_put, .push_word, .rx_busy, .rx_link, .rx_ack);

  always_ff @(posedge clk) begin
    if (reset) begin
      stalled <= 1'b0;
    end else if (step) begin
      stalled <= stall;   // Held while stopped
    end
  end

endmodule

/* verif/clk_gen.sv */
// Testbench clock and reset source
// 40 ns clock, reset held high for the first 5 cycles
`timescale 1ns/10ps
module clk_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
  end

  always #20 clk = ~clk;   // 40 ns period

endmodule

/* verif/pio_sm_tb.sv */
// PIO state machine testbench
// Loads small programs, runs the TX/RX link agents and checks results
`timescale 1ns/10ps
module pio_sm_tb import pio_pkg::*; ();

  localparam int TEST_CYCLES = 6 * 200;
  localparam int CYCLE_LIMIT = TEST_CYCLES + 400;   // Summed tests plus margin

  logic clk, gen_reset, soft_reset, reset_i, en, rx_ack, tx_ack, stalled, prev_pin;
  sm_cfg_t cfg;
  prog_wr_t prog_wr;
  link_t tx_link, rx_link;
  logic [DATA_W-1:0] gpio_in, gpio_out, gpio_dir, rx_word, w, r, rot;
  logic [PC_W-1:0] pc;
  logic [15:0] prog_buf [32];
  logic [31:0] rand_state = 32'h2e00f4f6;
  int cycles = 0, errors = 0, pass_count = 0, fail_count = 0, errs_before, pulses;

  clk_gen u_clk (.clk, .reset(gen_reset));
  assign reset_i = gen_reset | soft_reset;

  pio_sm uut (.clk, .reset(reset_i), .en, .cfg, .prog_wr, .gpio_in, .tx_link, .tx_ack,
              .rx_link, .rx_ack, .gpio_out, .gpio_dir, .pc, .stalled);

  function automatic logic [31:0] next_rand();
    rand_state = rand_state ^ (rand_state << 13);
    rand_state = rand_state ^ (rand_state >> 17);
    rand_state = rand_state ^ (rand_state << 5);
    return rand_state;
  endfunction

  function automatic logic [15:0] enc(input logic [2:0] op, input logic [2:0] a1,
                                      input logic [4:0] a2);
    return {op, 5'd0, a1, a2};
  endfunction

  function automatic logic [15:0] enc_mov(input logic [2:0] dst, input logic [1:0] mop,
                                          input logic [2:0] src);
    return {OP_MOV, 5'd0, dst, mop, src};
  endfunction

  function automatic sm_cfg_t base_cfg();
    sm_cfg_t c;
    c = '0;
    c.wrap_top = 5'd31;
    return c;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic ok, input string what);
    assert (ok) else begin
      $display("Check failed: %s", what);
      errors++;
    end
  endtask

  // Stop, reset, load n words and start with the given config
  task automatic run_program(input int n, input sm_cfg_t c);
    @(posedge clk);
    en         <= 1'b0;
    soft_reset <= 1'b1;
    @(posedge clk);
    soft_reset <= 1'b0;
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      prog_wr <= '{we: 1'b1, addr: i[PC_W-1:0], instr: prog_buf[i]};
    end
    @(posedge clk);
    prog_wr.we <= 1'b0;
    cfg        <= c;
    @(posedge clk);
    en <= 1'b1;
    errs_before = errors;
  endtask

  task automatic wait_pc(input logic [PC_W-1:0] target);
    do @(negedge clk); while (pc !== target);
  endtask

  task automatic send_tx(input logic [DATA_W-1:0] data);
    @(posedge clk);
    tx_link <= '{req: 1'b1, data: data};
    do @(negedge clk); while (!tx_ack);
    @(posedge clk);
    tx_link.req <= 1'b0;
    do @(negedge clk); while (tx_ack);
  endtask

  task automatic recv_rx(output logic [DATA_W-1:0] data);
    do @(negedge clk); while (!rx_link.req);
    data = rx_link.data;
    repeat (next_rand() % 4) @(posedge clk);   // Random ack delay
    @(posedge clk);
    rx_ack <= 1'b1;
    do @(negedge clk); while (rx_link.req);
    @(posedge clk);
    rx_ack <= 1'b0;
  endtask

  task automatic end_test(input string name);
    if (errors == errs_before) pass_count++;
    else fail_count++;
    $display("%s: %s", name, (errors == errs_before) ? "ok" : "errors");
  endtask

  // Rising edges on the first SET pin
  always @(negedge clk) begin
    if (reset_i) begin
      pulses   <= 0;
      prev_pin <= 1'b0;
    end else begin
      prev_pin <= gpio_out[2];
      if (gpio_out[2] && !prev_pin) pulses <= pulses + 1;
    end
  end

  a_tx_ack_after_req: assert property (@(posedge clk) disable iff (reset_i)
    $rose(tx_ack) |-> $past(tx_link.req)) else begin
    $display("TX ack rose without a request");
    errors++;
  end

  a_rx_data_hold: assert property (@(posedge clk) disable iff (reset_i)
    (rx_link.req && $past(rx_link.req)) |-> $stable(rx_link.data)) else begin
    $display("RX data changed while request was high");
    errors++;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    sm_cfg_t c;
    en <= 1'b0;
    soft_reset <= 1'b0;
    cfg <= base_cfg();
    prog_wr <= '0;
    gpio_in <= '0;
    tx_link <= '0;
    rx_ack <= 1'b0;
    do @(posedge clk); while (gen_reset);

    // Loop counting
    c = base_cfg();
    c.set_base = 5'd2;
    c.set_count = 3'd1;
    prog_buf[0] = enc(OP_SET, SRC_X, 5'd3);
    prog_buf[1] = enc(OP_SET, SRC_PINS, 5'd1);
    prog_buf[2] = enc(OP_SET, SRC_PINS, 5'd0);
    prog_buf[3] = enc(OP_JMP, COND_XDEC, 5'd1);
    prog_buf[4] = enc(OP_SET, SRC_Y, 5'd7);
    prog_buf[5] = enc(OP_JMP, COND_XNEY, 5'd5);
    run_program(6, c);
    wait_pc(5);
    repeat (10) @(negedge clk);
    check_val("pc", pc, 5);
    check_val("pulses", pulses, 4);
    end_test("loop counting");

    // PULL and OUT
    c = base_cfg();
    c.out_base = 5'd8;
    c.out_count = 6'd8;
    c.out_shift_right = 1'b1;
    prog_buf[0] = enc(OP_PUSHPULL, 3'b100, 5'd0);
    prog_buf[1] = enc(OP_OUT, SRC_PINS, 5'd8);
    prog_buf[2] = enc(OP_OUT, SRC_PINS, 5'd8);
    prog_buf[3] = enc(OP_JMP, COND_ALWAYS, 5'd3);
    run_program(4, c);
    repeat (6) @(negedge clk);
    check_true(stalled === 1'b1 && pc === 5'd0, "PULL did not stall without a TX word");
    w = next_rand();
    fork
      send_tx(w);
    join_none
    wait_pc(2);
    check_val("gpio_out[15:8]", gpio_out[15:8], w[7:0]);
    wait_pc(3);
    check_val("gpio_out[15:8]", gpio_out[15:8], w[15:8]);
    end_test("pull and out");

    // IN and PUSH
    c = base_cfg();
    c.in_base = 5'd4;
    c.in_shift_right = 1'b1;
    r = next_rand();
    @(posedge clk);
    gpio_in <= r;
    prog_buf[0] = enc(OP_IN, SRC_PINS, 5'd16);
    prog_buf[1] = enc(OP_PUSHPULL, 3'b000, 5'd0);
    prog_buf[2] = enc(OP_JMP, COND_ALWAYS, 5'd2);
    run_program(3, c);
    rot = (r >> 4) | (r << 28);
    recv_rx(rx_word);
    check_val("rx_link.data", rx_word, {rot[15:0], 16'h0000});
    end_test("in and push");

    // MOV views
    prog_buf[0] = enc(OP_SET, SRC_X, 5'd5);
    prog_buf[1] = enc_mov(SRC_ISR, MOVOP_INV, SRC_X);
    prog_buf[2] = enc(OP_PUSHPULL, 3'b000, 5'd0);
    prog_buf[3] = enc_mov(SRC_ISR, MOVOP_REV, SRC_X);
    prog_buf[4] = enc(OP_PUSHPULL, 3'b000, 5'd0);
    prog_buf[5] = enc(OP_JMP, COND_ALWAYS, 5'd5);
    run_program(6, base_cfg());
    recv_rx(rx_word);
    check_val("rx_link.data", rx_word, 32'hffff_fffa);
    recv_rx(rx_word);
    check_val("rx_link.data", rx_word, 32'ha000_0000);
    end_test("mov views");

    // RX back-pressure
    prog_buf[0] = enc(OP_SET, SRC_X, 5'd9);
    prog_buf[1] = enc_mov(SRC_ISR, MOVOP_NONE, SRC_X);
    prog_buf[2] = enc(OP_PUSHPULL, 3'b000, 5'd0);
    prog_buf[3] = enc(OP_SET, SRC_X, 5'd17);
    prog_buf[4] = enc_mov(SRC_ISR, MOVOP_NONE, SRC_X);
    prog_buf[5] = enc(OP_PUSHPULL, 3'b000, 5'd0);
    prog_buf[6] = enc(OP_JMP, COND_ALWAYS, 5'd6);
    run_program(7, base_cfg());
    wait_pc(5);
    repeat (8) @(negedge clk);
    check_true(stalled === 1'b1 && pc === 5'd5, "second PUSH did not stall");
    check_true(rx_link.req === 1'b1, "RX request dropped without ack");
    check_val("rx_link.data", rx_link.data, 32'd9);
    recv_rx(rx_word);
    check_val("rx_link.data", rx_word, 32'd9);
    recv_rx(rx_word);
    check_val("rx_link.data", rx_word, 32'd17);
    end_test("rx back-pressure");

    // WAIT and PINDIRS
    c = base_cfg();
    c.jmp_pin = 5'd20;
    c.set_base = 5'd2;
    c.set_count = 3'd3;
    @(posedge clk);
    gpio_in <= '0;
    prog_buf[0] = enc(OP_WAIT, 3'b100, 5'd20);
    prog_buf[1] = enc(OP_SET, DST_PINDIRS, 5'd5);
    prog_buf[2] = enc(OP_JMP, COND_ALWAYS, 5'd2);
    run_program(3, c);
    repeat (6) @(negedge clk);
    check_true(stalled === 1'b1 && pc === 5'd0, "WAIT did not stall on a low pin");
    @(posedge clk);
    gpio_in <= 32'h1 << 20;
    wait_pc(2);
    check_val("gpio_dir", gpio_dir, 32'h0000_0014);
    end_test("wait and pindirs");

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
hdl/pio_pkg.sv
hdl/tx_receiver.sv
hdl/sequencer.sv
hdl/exec_unit.sv
hdl/rx_sender.sv
hdl/pio_sm.sv
verif/clk_gen.sv
verif/pio_sm_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the PIO state machine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module pio_sm_tb -f files.f -o sim_pio

out=$(./obj_dir/sim_pio)
echo "$out"

if echo "$out" | grep -q "TEST PASSED"; then
  exit 0
else
  exit 1
fi
